// File: rtl/dac_intf_pkg.sv
// shared widths, counts, vector typedefs and the tx flag struct of the dac interface
package dac_intf_pkg;

    // sample and dac word geometry
    localparam int IQ_WIDTH     = 16;                          // one I or Q component
    localparam int SAMPLE_WIDTH = 2 * IQ_WIDTH;                // packed {I, Q} sample
    localparam int DAC_WIDTH    = 2 * SAMPLE_WIDTH;            // one sample slot per antenna

    // baseband pacing, 4 acc_clk cycles per 20 Msps sample
    localparam int NUM_CLK_PER_SAMPLE = 4;
    localparam int PACE_CNT_W         = $clog2(NUM_CLK_PER_SAMPLE);

    // dual-clock fifo geometry
    localparam int FIFO_DEPTH = 32;                            // words in the register array
    localparam int FIFO_AW    = 5;                             // address bits, pointer adds a wrap bit

    // destination flops in the flag synchronizer
    localparam int SYNC_STAGES = 4;

    typedef logic [SAMPLE_WIDTH-1:0] iq_sample_t;              // one IQ sample
    typedef logic [DAC_WIDTH-1:0]    dac_word_t;               // {antenna 1, antenna 0}
    typedef logic [FIFO_AW:0]        fifo_ptr_t;               // msb is the wrap bit
    typedef logic [PACE_CNT_W-1:0]   pace_cnt_t;               // sample period counter

    localparam pace_cnt_t PACE_CNT_TOP = pace_cnt_t'(NUM_CLK_PER_SAMPLE - 1); // last count

    // antenna and cdd control, quasi static in acc_clk
    typedef struct packed {
        logic ant_sel;                                         // route to antenna 1 when set
        logic cdd_dup;                                         // same word on both antennas, wins
        logic cdd_delay;                                       // antenna 1 gets the word two pops back
    } tx_flags_t;

endpackage

// File: rtl/sample_pacer.sv
// sample_pacer module: sample period counter, upstream read strobes, sample plus zero fifo writes
`timescale 1ns/1ps

module sample_pacer (
    input  logic                    acc_clk,
    input  logic                    acc_rstn,
    input  dac_intf_pkg::iq_sample_t data_from_acc,       // offered by the baseband source
    output logic                    read_bb_fifo,         // one-cycle pull strobe per sample period
    output logic                    read_bb_fifo_delay,   // strobe copy one cycle later
    output logic                    wr_en,                // two cycles per period into the fifo
    output dac_intf_pkg::iq_sample_t wr_data              // sample, then the inserted zero
);
    import dac_intf_pkg::*;

    pace_cnt_t sample_cnt;                                 // position inside the sample period
    logic      slot_sample;                                // count where the sample is taken
    logic      slot_zero;                                  // count right after, zero insertion

    assign slot_sample = (sample_cnt == pace_cnt_t'(0));   // strobe and capture happen here
    assign slot_zero   = (sample_cnt == pace_cnt_t'(1));   // second write of the pair

    // control state, counter starts at 0 in the first cycle after reset
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            sample_cnt         <= '0;
            read_bb_fifo       <= 1'b0;
            read_bb_fifo_delay <= 1'b0;
            wr_en              <= 1'b0;
        end else begin
            if (sample_cnt == PACE_CNT_TOP) begin
                sample_cnt <= '0;                          // wrap at the end of the period
            end else begin
                sample_cnt <= sample_cnt + pace_cnt_t'(1);
            end
            read_bb_fifo       <= slot_sample;             // high in the cycle after count 0
            read_bb_fifo_delay <= read_bb_fifo;            // follows the strobe by one cycle
            wr_en              <= slot_sample | slot_zero; // 2x interpolation needs two writes
        end
    end

    // payload, takes the offered sample on the edge where the strobe rises
    always_ff @(posedge acc_clk) begin
        if (slot_sample) begin
            wr_data <= data_from_acc;                      // first write carries the sample
        end else begin
            wr_data <= '0;                                 // second write carries the zero
        end
    end

endmodule

// File: rtl/async_sample_fifo.sv
// async_sample_fifo module with dual-clock fwft storage, gray pointer crossing and sticky overflow
`timescale 1ns/1ps

module async_sample_fifo (
    input  logic                    acc_clk,
    input  logic                    acc_rstn,
    input  logic                    wr_en,               // write request from the pacer
    input  dac_intf_pkg::iq_sample_t wr_data,
    input  logic                    dac_clk,
    input  logic                    dac_rstn,
    input  logic                    rd_en,               // pop request that only counts while not_empty
    output logic                    overflow,            // sticky in acc_clk until acc_rstn
    output dac_intf_pkg::iq_sample_t head,               // oldest word while not_empty is high
    output logic                    not_empty
);
    import dac_intf_pkg::*;

    iq_sample_t mem [FIFO_DEPTH];                          // word storage

    // write side in acc_clk
    fifo_ptr_t wr_ptr;                                     // binary write pointer with wrap bit
    fifo_ptr_t wr_ptr_nxt;
    fifo_ptr_t wr_gray;                                    // registered gray copy that crosses
    fifo_ptr_t rd_gray_s1;                                 // read pointer entering acc_clk
    fifo_ptr_t rd_gray_s2;
    logic      full;
    logic      wr_accept;

    // read side in dac_clk
    fifo_ptr_t rd_ptr;                                     // binary read pointer with wrap bit
    fifo_ptr_t rd_ptr_nxt;
    fifo_ptr_t rd_gray;
    fifo_ptr_t wr_gray_s1;                                 // write pointer entering dac_clk
    fifo_ptr_t wr_gray_s2;
    logic      empty;
    logic      rd_accept;

    function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
        return bin ^ (bin >> 1);                           // one bit changes per increment
    endfunction

    assign wr_ptr_nxt = wr_ptr + fifo_ptr_t'(1);
    assign rd_ptr_nxt = rd_ptr + fifo_ptr_t'(1);

    // full when the gray pointers differ only in the two top bits
    assign full      = (wr_gray == {~rd_gray_s2[FIFO_AW -: 2], rd_gray_s2[FIFO_AW-2:0]});
    assign wr_accept = wr_en & ~full;                      // a write into a full fifo is dropped

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            wr_ptr     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            overflow   <= 1'b0;
        end else begin
            rd_gray_s1 <= rd_gray;                         // two-flop synchronizer
            rd_gray_s2 <= rd_gray_s1;
            if (wr_accept) begin
                wr_ptr  <= wr_ptr_nxt;
                wr_gray <= bin2gray(wr_ptr_nxt);           // stays in step with wr_ptr
            end
            if (wr_en && full) begin
                overflow <= 1'b1;                          // held until the next acc reset
            end
        end
    end

    always_ff @(posedge acc_clk) begin
        if (wr_accept) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
        end
    end

    // empty when the read gray pointer has caught up with the synchronized write pointer
    assign empty     = (rd_gray == wr_gray_s2);
    assign not_empty = ~empty;
    assign rd_accept = rd_en & not_empty;                  // a pop on empty is ignored
    assign head      = mem[rd_ptr[FIFO_AW-1:0]];           // first word falls through

    always_ff @(posedge dac_clk) begin
        if (!dac_rstn) begin
            rd_ptr     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;                         // two-flop synchronizer
            wr_gray_s2 <= wr_gray_s1;
            if (rd_accept) begin
                rd_ptr  <= rd_ptr_nxt;                     // next word shows on head after the edge
                rd_gray <= bin2gray(rd_ptr_nxt);
            end
        end
    end

endmodule

// File: rtl/flag_sync.sv
// flag_sync module: source register plus multi-stage dac_clk synchronizer for the tx flags
`timescale 1ns/1ps

module flag_sync (
    input  logic                   acc_clk,
    input  logic                   acc_rstn,
    input  dac_intf_pkg::tx_flags_t flags,             // quasi-static level from acc_clk
    input  logic                   dac_clk,
    input  logic                   dac_rstn,
    output dac_intf_pkg::tx_flags_t flags_dac          // flags as seen in dac_clk
);
    import dac_intf_pkg::*;

    tx_flags_t flags_src;                               // registered in the source domain
    tx_flags_t sync_q [SYNC_STAGES];                    // destination flop chain

    // source register so no combinational path reaches the crossing
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            flags_src <= '0;
        end else begin
            flags_src <= flags;
        end
    end

    // bits may land a cycle apart, acceptable since the flags change rarely
    always_ff @(posedge dac_clk) begin
        if (!dac_rstn) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= flags_src;                     // first flop may go metastable
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign flags_dac = sync_q[SYNC_STAGES-1];           // last stage is settled

endmodule

// File: rtl/antenna_mapper.sv
// antenna_mapper module: pop handshake, two-word delay line and 64-bit antenna packing
`timescale 1ns/1ps

module antenna_mapper (
    input  logic                    dac_clk,
    input  logic                    dac_rstn,
    input  dac_intf_pkg::iq_sample_t head,               // fifo head word
    input  logic                    not_empty,
    input  logic                    dac_ready,           // dac accepts a word this cycle
    input  dac_intf_pkg::tx_flags_t  flags_dac,           // synchronized mode flags
    output logic                    rd_en,               // pop request back to the fifo
    output logic                    dac_valid,
    output dac_intf_pkg::dac_word_t  dac_data            // {antenna 1, antenna 0}
);
    import dac_intf_pkg::*;

    iq_sample_t dly1;                                      // word popped one pop earlier
    iq_sample_t dly2;                                      // word popped two pops earlier
    dac_word_t  single_ant;                                // head on one antenna, zero on the other

    assign dac_valid = not_empty;                          // stalls show up as dac_valid low
    assign rd_en     = dac_valid & dac_ready;              // accepted word pops the fifo

    // delay line only moves on accepted pops, so stalls keep the alignment
    always_ff @(posedge dac_clk) begin
        if (!dac_rstn) begin
            dly1 <= '0;
            dly2 <= '0;
        end else if (rd_en) begin
            dly1 <= head;
            dly2 <= dly1;                                  // one baseband sample is two pops
        end
    end

    // plain routing to the selected antenna
    always_comb begin
        if (flags_dac.ant_sel) begin
            single_ant = {head, {SAMPLE_WIDTH{1'b0}}};     // antenna 1 in the upper half
        end else begin
            single_ant = {{SAMPLE_WIDTH{1'b0}}, head};     // antenna 0 in the lower half
        end
    end

    // duplicate wins over delay, delay wins over plain routing
    always_comb begin
        if (flags_dac.cdd_dup) begin
            dac_data = {head, head};
        end else if (flags_dac.cdd_delay) begin
            dac_data = {dly2, head};                       // cyclic delay of one sample on antenna 1
        end else begin
            dac_data = single_ant;
        end
    end

endmodule

// File: rtl/dac_intf_top.sv
// dac_intf_top module: pacer, dual-clock fifo, flag synchronizer and antenna mapper wiring
`timescale 1ns/1ps

module dac_intf_top (
    input  logic                    acc_clk,
    input  logic                    acc_rstn,
    input  logic                    dac_clk,
    input  logic                    dac_rstn,
    input  dac_intf_pkg::iq_sample_t data_from_acc,      // baseband sample offered upstream
    input  dac_intf_pkg::tx_flags_t  flags,               // antenna and cdd mode in acc_clk
    input  logic                    dac_ready,           // dac side back-pressure
    output logic                    read_bb_fifo,        // pull strobe to the baseband fifo
    output logic                    read_bb_fifo_delay,
    output logic                    overflow,            // sticky, pacer outran the dac
    output logic                    dac_valid,
    output dac_intf_pkg::dac_word_t  dac_data
);
    import dac_intf_pkg::*;

    logic       wr_en;                                     // pacer to fifo write strobe
    iq_sample_t wr_data;                                   // sample or inserted zero
    iq_sample_t head;                                      // fifo head into the mapper
    logic       not_empty;
    logic       rd_en;                                     // mapper pop back into the fifo
    tx_flags_t  flags_dac;                                 // flags after the crossing

    // acc_clk side, 20 Msps pull and 40 Msps write
    sample_pacer u_sample_pacer (
        .acc_clk            (acc_clk),
        .acc_rstn           (acc_rstn),
        .data_from_acc      (data_from_acc),
        .read_bb_fifo       (read_bb_fifo),
        .read_bb_fifo_delay (read_bb_fifo_delay),
        .wr_en              (wr_en),
        .wr_data            (wr_data)
    );

    // sample data crossing
    async_sample_fifo u_async_sample_fifo (
        .acc_clk   (acc_clk),
        .acc_rstn  (acc_rstn),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .dac_clk   (dac_clk),
        .dac_rstn  (dac_rstn),
        .rd_en     (rd_en),
        .overflow  (overflow),
        .head      (head),
        .not_empty (not_empty)
    );

    // mode flag crossing, runs beside the fifo
    flag_sync u_flag_sync (
        .acc_clk   (acc_clk),
        .acc_rstn  (acc_rstn),
        .flags     (flags),
        .dac_clk   (dac_clk),
        .dac_rstn  (dac_rstn),
        .flags_dac (flags_dac)
    );

    // dac_clk side, joins data and flags into the dac word
    antenna_mapper u_antenna_mapper (
        .dac_clk   (dac_clk),
        .dac_rstn  (dac_rstn),
        .head      (head),
        .not_empty (not_empty),
        .dac_ready (dac_ready),
        .flags_dac (flags_dac),
        .rd_en     (rd_en),
        .dac_valid (dac_valid),
        .dac_data  (dac_data)
    );

endmodule

// File: tb/dac_intf_checker.sv
// dac_intf_checker assertions on strobe shape, sticky overflow and reset state, and their bind
`timescale 1ns/1ps

module dac_intf_checker (
    input logic acc_clk,
    input logic acc_rstn,
    input logic dac_clk,
    input logic dac_rstn,
    input logic read_bb_fifo,
    input logic read_bb_fifo_delay,
    input logic overflow,
    input logic dac_valid
);
    import dac_intf_pkg::*;

    int assert_failures = 0;                               // failed assertions so far

    // one single-cycle pull per sample period with the next one NUM_CLK_PER_SAMPLE cycles later
    strobe_spacing: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        read_bb_fifo |=> (!read_bb_fifo) [* (NUM_CLK_PER_SAMPLE - 1)] ##1 read_bb_fifo)
        else begin
            assert_failures++;
            $error("read_bb_fifo is not a one cycle pulse once per sample period");
        end

    // the delayed copy trails the strobe by one acc_clk cycle
    delay_follows: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        read_bb_fifo_delay == $past(read_bb_fifo))
        else begin
            assert_failures++;
            $error("read_bb_fifo_delay does not follow read_bb_fifo by one cycle");
        end

    // once a write was dropped the flag holds until the next acc reset
    overflow_sticky: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        !$fell(overflow))
        else begin
            assert_failures++;
            $error("overflow fell while acc_rstn was released");
        end

    // the edge that sees reset clears the strobes and the overflow flag
    acc_reset_quiet: assert property (@(posedge acc_clk)
        !acc_rstn |=> (!read_bb_fifo && !read_bb_fifo_delay && !overflow))
        else begin
            assert_failures++;
            $error("strobes or overflow were high during acc reset");
        end

    // fifo pointers reset together so the dac side shows nothing to pop
    dac_reset_quiet: assert property (@(posedge dac_clk) !dac_rstn |=> !dac_valid)
        else begin
            assert_failures++;
            $error("dac_valid was high during dac reset");
        end

endmodule

bind dac_intf_top dac_intf_checker u_dac_intf_checker (
    .acc_clk            (acc_clk),
    .acc_rstn           (acc_rstn),
    .dac_clk            (dac_clk),
    .dac_rstn           (dac_rstn),
    .read_bb_fifo       (read_bb_fifo),
    .read_bb_fifo_delay (read_bb_fifo_delay),
    .overflow           (overflow),
    .dac_valid          (dac_valid)
);

// File: tb/dac_intf_tb.sv
// dac_intf_tb module with clocks, resets, random stimulus, dac word model, value check and watchdog
`timescale 1ns/1ps

module dac_intf_tb;
    import dac_intf_pkg::*;

    localparam int  SEED             = 39882;
    localparam real ACC_HALF_NS      = 2.0;                // 4 ns acc_clk
    localparam real DAC_HALF_NS      = 3.5;                // 7 ns dac_clk
    localparam int  RESET_CYCLES     = 16;
    localparam int  SKIP_WORDS       = 12;                 // flags cross the synchronizer meanwhile
    localparam int  CHECK_WORDS      = 100;
    localparam int  NUM_DATA_PHASES  = 4;
    localparam int  OVF_HOLD_PERIODS = 40;                 // the fifo fills long before this ends
    localparam int  OVF_STAY_PERIODS = 8;
    localparam int  SAMPLE_PERIOD_NS = 4 * NUM_CLK_PER_SAMPLE;
    localparam int  RUN_LENGTH       = RESET_CYCLES + NUM_DATA_PHASES * (SKIP_WORDS + CHECK_WORDS)
                                       + OVF_HOLD_PERIODS + OVF_STAY_PERIODS;
    localparam int  TIMEOUT_NS       = RUN_LENGTH * 8 * SAMPLE_PERIOD_NS;

    logic       acc_clk;
    logic       acc_rstn;
    logic       dac_clk;
    logic       dac_rstn;
    iq_sample_t data_from_acc;
    tx_flags_t  flags;
    logic       dac_ready;
    logic       read_bb_fifo;
    logic       read_bb_fifo_delay;
    logic       overflow;
    logic       dac_valid;
    dac_word_t  dac_data;

    iq_sample_t model_q [$];                               // fifo words in write order
    iq_sample_t hist1 = '0;                                // model word popped one pop back
    iq_sample_t hist2 = '0;                                // model word popped two pops back
    iq_sample_t popped;
    int         accepted_total = 0;                        // accepted dac words since reset
    int         phase_start = 0;                           // accepted_total when the phase began
    bit         check_en = 1'b0;
    string      phase_name = "reset";
    int         ready_pct = 0;                             // chance of dac_ready per dac cycle
    int         acc_cycles = 0;                            // acc_clk edges after reset release
    int         strobe_count = 0;
    logic       prev_strobe = 1'b0;
    bit         watch_ovf_low = 1'b0;
    bit         watch_ovf_high = 1'b0;

    dac_intf_top UUT (
        .acc_clk            (acc_clk),
        .acc_rstn           (acc_rstn),
        .dac_clk            (dac_clk),
        .dac_rstn           (dac_rstn),
        .data_from_acc      (data_from_acc),
        .flags              (flags),
        .dac_ready          (dac_ready),
        .read_bb_fifo       (read_bb_fifo),
        .read_bb_fifo_delay (read_bb_fifo_delay),
        .overflow           (overflow),
        .dac_valid          (dac_valid),
        .dac_data           (dac_data)
    );

    initial begin
        acc_clk = 1'b0;
        forever #(ACC_HALF_NS) acc_clk = ~acc_clk;
    end

    initial begin
        dac_clk = 1'b0;
        forever #(DAC_HALF_NS) dac_clk = ~dac_clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // dac word from the mode rules where duplication wins over delay and delay over routing
    function automatic dac_word_t expected_word(input tx_flags_t f, input iq_sample_t h,
                                                input iq_sample_t two_back);
        if (f.cdd_dup) begin
            return {h, h};
        end else if (f.cdd_delay) begin
            return {two_back, h};                          // antenna 1 lags by one sample
        end else if (f.ant_sel) begin
            return {h, iq_sample_t'(0)};
        end
        return {iq_sample_t'(0), h};
    endfunction

    // new ready percentage from the next dac_clk rising edge on
    task automatic set_ready(input int pct);
        @(posedge dac_clk);
        ready_pct = pct;
    endtask

    task automatic run_phase(input string name, input tx_flags_t f, input int pct);
        set_ready(pct);
        @(negedge acc_clk);
        phase_name  = name;
        flags       = f;
        phase_start = accepted_total;                      // first SKIP_WORDS are not compared
        check_en    = 1'b1;
        while (accepted_total < phase_start + SKIP_WORDS + CHECK_WORDS) begin
            @(negedge acc_clk);
        end
    endtask

    // the source offers a new sample once the current one was pulled
    always @(negedge acc_clk) begin
        if (read_bb_fifo === 1'b1) begin
            model_q.push_back(data_from_acc);              // captured sample
            model_q.push_back(iq_sample_t'(0));            // inserted zero
            data_from_acc = $urandom;
        end
    end

    always @(negedge dac_clk) begin
        dac_ready = ($urandom_range(99) < ready_pct);
    end

    // values read here are the ones that stood before the edge
    always @(posedge dac_clk) begin
        if (dac_rstn && dac_valid && dac_ready) begin
            if (model_q.size() == 0) begin
                report_failure("the DAC accepted a word that the model never queued");
            end else begin
                popped = model_q.pop_front();
                if (check_en && (accepted_total - phase_start) >= SKIP_WORDS) begin
                    check_value(phase_name, expected_word(flags, popped, hist2), dac_data);
                end
                hist2 = hist1;
                hist1 = popped;
                accepted_total++;
            end
        end
    end

    // strobe pacing and overflow level as they stood before each acc_clk edge
    always @(posedge acc_clk) begin
        if (acc_rstn) begin
            acc_cycles++;
            if (read_bb_fifo) begin
                strobe_count++;
            end
            check_value("pacing_delay", 64'(prev_strobe), 64'(read_bb_fifo_delay));
            prev_strobe = read_bb_fifo;
            if (watch_ovf_low) begin
                check_value("overflow_low", 64'(0), 64'(overflow));
            end
            if (watch_ovf_high) begin
                check_value("overflow_held", 64'(1), 64'(overflow));
            end
        end
    end

    initial begin
        wait (UUT.u_dac_intf_checker.assert_failures != 0);
        report_failure("a concurrent assertion in the bound checker failed");
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure("watchdog expired before all phases finished");
    end

    initial begin
        tx_flags_t f;
        int        expected_pulses;
        void'($urandom(SEED));
        acc_rstn      = 1'b0;
        dac_rstn      = 1'b0;
        data_from_acc = $urandom;
        flags         = '0;
        dac_ready     = 1'b0;
        repeat (RESET_CYCLES) @(posedge acc_clk);          // reset seen on RESET_CYCLES edges
        @(negedge acc_clk);
        acc_rstn = 1'b1;
        @(negedge dac_clk);
        dac_rstn = 1'b1;
        @(negedge acc_clk);
        watch_ovf_low = 1'b1;                              // no drops while the dac keeps up

        f = '0;
        run_phase("antenna_0", f, 100);
        f.ant_sel = 1'b1;
        run_phase("antenna_1", f, 90);
        f = '0;
        f.cdd_dup = 1'b1;
        f.ant_sel = 1'($urandom_range(1));                 // must not matter under duplication
        run_phase("cdd_dup", f, 95);
        f = '0;
        f.cdd_delay = 1'b1;
        run_phase("cdd_delay", f, 95);

        // sustained back-pressure lets the pacer write into a full fifo
        set_ready(0);
        @(negedge acc_clk);
        check_en      = 1'b0;
        watch_ovf_low = 1'b0;
        phase_name    = "overflow";
        repeat (OVF_HOLD_PERIODS * NUM_CLK_PER_SAMPLE) @(negedge acc_clk);
        check_value("overflow", 64'(1), 64'(overflow));
        watch_ovf_high = 1'b1;
        repeat (OVF_STAY_PERIODS * NUM_CLK_PER_SAMPLE) @(negedge acc_clk);

        expected_pulses = acc_cycles / NUM_CLK_PER_SAMPLE;
        if (strobe_count > expected_pulses + 1 || strobe_count + 1 < expected_pulses) begin
            check_value("pacing_count", 64'(expected_pulses), 64'(strobe_count));
        end
        if (UUT.u_dac_intf_checker.assert_failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/dac_intf_pkg.sv
rtl/sample_pacer.sv
rtl/async_sample_fifo.sv
rtl/flag_sync.sv
rtl/antenna_mapper.sv
rtl/dac_intf_top.sv
tb/dac_intf_checker.sv
tb/dac_intf_tb.sv
